// ==== src/csr_map_pkg.sv ====
`default_nettype none

package csr_map_pkg;

    localparam int CSR_NUM_W  = 14;
    localparam int CSR_DATA_W = 32;

    // Architectural CSR numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h0000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h0001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h0004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h0005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h0006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h0007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h000c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h0030;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h0031;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h0032;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h0033;
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h0040;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h0041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h0042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h0044;

    typedef enum logic [4:0] {
        IDX_NONE, IDX_CRMD, IDX_PRMD, IDX_ECFG, IDX_ESTAT, IDX_ERA, IDX_BADV, IDX_EENTRY,
        IDX_SAVE0, IDX_SAVE1, IDX_SAVE2, IDX_SAVE3, IDX_TID, IDX_TCFG, IDX_TVAL, IDX_TICLR
    } csr_idx_t;

    // Bits that software may change
    localparam logic [CSR_DATA_W-1:0] CRMD_WMASK   = 32'h0000_0007;
    localparam logic [CSR_DATA_W-1:0] PRMD_WMASK   = 32'h0000_0007;
    localparam logic [CSR_DATA_W-1:0] ECFG_WMASK   = 32'h0000_1bff;
    localparam logic [CSR_DATA_W-1:0] ESTAT_WMASK  = 32'h0000_0003;
    localparam logic [CSR_DATA_W-1:0] EENTRY_WMASK = 32'hffff_ffc0;
    localparam logic [CSR_DATA_W-1:0] TCFG_WMASK   = 32'hffff_ffff;
    localparam logic [CSR_DATA_W-1:0] SAVE_WMASK   = 32'hffff_ffff;

    localparam logic                  CRMD_DA_CONST = 1'b1;
    localparam logic [CSR_DATA_W-1:0] TIMER_IDLE    = 32'hffff_ffff;
    localparam int                    TIMER_IRQ_BIT = 11;

    // Old value with the masked bits taken from the new one
    function automatic logic [CSR_DATA_W-1:0] csr_merge(
        input logic [CSR_DATA_W-1:0] old_val,
        input logic [CSR_DATA_W-1:0] new_val,
        input logic [CSR_DATA_W-1:0] mask
    );
        return (mask & new_val) | (~mask & old_val);
    endfunction

endpackage

`default_nettype wire

// ==== src/csr_exc_pkg.sv ====
`default_nettype none

package csr_exc_pkg;

    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;

    // Address errors, the only codes that load BADV
    localparam logic [ECODE_W-1:0] ECODE_ADE = 6'h08;
    localparam logic [ECODE_W-1:0] ECODE_ALE = 6'h09;

    // Fetch side of ADE, BADV takes the pc
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = 9'h000;

    // ESTAT.IS and ECFG.LIE
    localparam int IS_W = 13;

endpackage

`default_nettype wire

// ==== src/csr_bus_ctrl.sv ====
`default_nettype none

module csr_bus_ctrl
    import csr_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [CSR_NUM_W-1:0]  wb_adr,
    input  logic [CSR_DATA_W-1:0] wb_dat_w,
    input  logic [CSR_DATA_W-1:0] wb_mask,
    output logic                  wb_ack,
    output logic [CSR_DATA_W-1:0] wb_dat_r,

    input  logic [CSR_DATA_W-1:0] rd_exc,
    input  logic [CSR_DATA_W-1:0] rd_timer,
    input  logic [CSR_DATA_W-1:0] rd_save,

    output logic                  wr_en,
    output csr_idx_t              idx,
    output logic [CSR_DATA_W-1:0] wr_data,
    output logic [CSR_DATA_W-1:0] wr_mask
);

    logic req;

    // New request, not yet acknowledged
    assign req = wb_cyc & wb_stb & ~wb_ack;

    always_comb begin
        case (wb_adr)
            CSR_CRMD:   idx = IDX_CRMD;
            CSR_PRMD:   idx = IDX_PRMD;
            CSR_ECFG:   idx = IDX_ECFG;
            CSR_ESTAT:  idx = IDX_ESTAT;
            CSR_ERA:    idx = IDX_ERA;
            CSR_BADV:   idx = IDX_BADV;
            CSR_EENTRY: idx = IDX_EENTRY;
            CSR_SAVE0:  idx = IDX_SAVE0;
            CSR_SAVE1:  idx = IDX_SAVE1;
            CSR_SAVE2:  idx = IDX_SAVE2;
            CSR_SAVE3:  idx = IDX_SAVE3;
            CSR_TID:    idx = IDX_TID;
            CSR_TCFG:   idx = IDX_TCFG;
            CSR_TVAL:   idx = IDX_TVAL;
            CSR_TICLR:  idx = IDX_TICLR;
            default:    idx = IDX_NONE;
        endcase
    end

    // Registers commit at the edge that raises wb_ack
    assign wr_en   = req & wb_we;
    assign wr_data = wb_dat_w;
    assign wr_mask = wb_mask;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Unmapped numbers merge to zero
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_exc | rd_timer | rd_save;
        end
    end

endmodule

`default_nettype wire

// ==== src/csr_exc_regs.sv ====
`default_nettype none

module csr_exc_regs
    import csr_map_pkg::*;
    import csr_exc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  wr_en,
    input  csr_idx_t              idx,
    input  logic [CSR_DATA_W-1:0] wr_data,
    input  logic [CSR_DATA_W-1:0] wr_mask,
    output logic [CSR_DATA_W-1:0] rd_word,

    input  logic                  ex_valid,
    input  logic [ECODE_W-1:0]    ex_ecode,
    input  logic [ESUBCODE_W-1:0] ex_esubcode,
    input  logic [CSR_DATA_W-1:0] ex_pc,
    input  logic [CSR_DATA_W-1:0] ex_vaddr,
    input  logic                  ertn,
    input  logic                  timer_irq,

    output logic [CSR_DATA_W-1:0] ex_entry,
    output logic [CSR_DATA_W-1:0] era_pc,
    output logic                  has_int,
    output logic                  ticlr_wr
);

    logic [1:0]            crmd_plv;
    logic                  crmd_ie;
    logic [1:0]            prmd_pplv;
    logic                  prmd_pie;
    logic [IS_W-1:0]       ecfg_lie;
    logic [1:0]            estat_is_sw;
    logic [ECODE_W-1:0]    estat_ecode;
    logic [ESUBCODE_W-1:0] estat_esubcode;
    logic [CSR_DATA_W-1:0] era;
    logic [CSR_DATA_W-1:0] badv;
    logic [25:0]           eentry_va;

    logic [IS_W-1:0]       estat_is;
    logic [CSR_DATA_W-1:0] crmd_word, prmd_word, ecfg_word, estat_word;
    logic [CSR_DATA_W-1:0] crmd_new, prmd_new, ecfg_new, estat_new, era_new, eentry_new;
    logic                  addr_err;

    always_comb begin
        estat_is = '0;
        estat_is[1:0] = estat_is_sw;
        estat_is[TIMER_IRQ_BIT] = timer_irq;
    end

    assign crmd_word  = {28'b0, CRMD_DA_CONST, crmd_ie, crmd_plv};
    assign prmd_word  = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_word  = {19'b0, ecfg_lie};
    assign estat_word = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign ex_entry   = {eentry_va, 6'b0};
    assign era_pc     = era;

    assign crmd_new   = csr_merge(crmd_word, wr_data, wr_mask & CRMD_WMASK);
    assign prmd_new   = csr_merge(prmd_word, wr_data, wr_mask & PRMD_WMASK);
    assign ecfg_new   = csr_merge(ecfg_word, wr_data, wr_mask & ECFG_WMASK);
    assign estat_new  = csr_merge(estat_word, wr_data, wr_mask & ESTAT_WMASK);
    assign era_new    = csr_merge(era, wr_data, wr_mask);
    assign eentry_new = csr_merge(ex_entry, wr_data, wr_mask & EENTRY_WMASK);

    assign addr_err = (ex_ecode == ECODE_ADE) || (ex_ecode == ECODE_ALE);
    assign ticlr_wr = wr_en && (idx == IDX_TICLR) && wr_mask[0] && wr_data[0];
    assign has_int  = ((estat_is & ecfg_lie) != '0) && crmd_ie;

    // Exception first, then ertn, then the bus
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ex_valid) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_en && idx == IDX_CRMD) begin
            crmd_plv <= crmd_new[1:0];
            crmd_ie  <= crmd_new[2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie    <= '0;
            estat_is_sw <= 2'b0;
        end else if (wr_en) begin
            if (idx == IDX_ECFG)
                ecfg_lie <= ecfg_new[IS_W-1:0];
            if (idx == IDX_ESTAT)
                estat_is_sw <= estat_new[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= crmd_ie;
            estat_ecode    <= ex_ecode;
            estat_esubcode <= ex_esubcode;
            era            <= ex_pc;
        end else if (wr_en && idx == IDX_PRMD) begin
            prmd_pplv <= prmd_new[1:0];
            prmd_pie  <= prmd_new[2];
        end else if (wr_en && idx == IDX_ERA) begin
            era <= era_new;
        end
        // Fetch errors report the pc itself
        if (ex_valid && addr_err)
            badv <= (ex_ecode == ECODE_ADE && ex_esubcode == ESUBCODE_ADEF) ? ex_pc : ex_vaddr;
        if (wr_en && idx == IDX_EENTRY)
            eentry_va <= eentry_new[31:6];
    end

    always_comb begin
        case (idx)
            IDX_CRMD:   rd_word = crmd_word;
            IDX_PRMD:   rd_word = prmd_word;
            IDX_ECFG:   rd_word = ecfg_word;
            IDX_ESTAT:  rd_word = estat_word;
            IDX_ERA:    rd_word = era;
            IDX_BADV:   rd_word = badv;
            IDX_EENTRY: rd_word = ex_entry;
            default:    rd_word = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/csr_timer.sv ====
`default_nettype none

module csr_timer
    import csr_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  wr_en,
    input  csr_idx_t              idx,
    input  logic [CSR_DATA_W-1:0] wr_data,
    input  logic [CSR_DATA_W-1:0] wr_mask,
    input  logic                  ticlr_wr,

    output logic [CSR_DATA_W-1:0] rd_word,
    output logic                  timer_irq
);

    logic [CSR_DATA_W-1:0] tid;
    logic                  tcfg_en;
    logic                  tcfg_periodic;
    logic [29:0]           tcfg_initval;
    logic [CSR_DATA_W-1:0] timer_cnt;

    logic [CSR_DATA_W-1:0] tcfg_word;
    logic [CSR_DATA_W-1:0] tcfg_new;
    logic                  tcfg_wr;

    assign tcfg_word = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_new  = csr_merge(tcfg_word, wr_data, wr_mask & TCFG_WMASK);
    assign tcfg_wr   = wr_en && (idx == IDX_TCFG);

    always_ff @(posedge clk) begin
        if (wr_en && idx == IDX_TID)
            tid <= csr_merge(tid, wr_data, wr_mask);
        if (tcfg_wr) begin
            tcfg_periodic <= tcfg_new[1];
            tcfg_initval  <= tcfg_new[31:2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en   <= 1'b0;
            timer_cnt <= TIMER_IDLE;
        end else begin
            if (tcfg_wr)
                tcfg_en <= tcfg_new[0];
            // Load from the merged value so a single write can start the timer
            if (tcfg_wr && tcfg_new[0]) begin
                timer_cnt <= {tcfg_new[31:2], 2'b0};
            end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
                if (timer_cnt == '0 && tcfg_periodic)
                    timer_cnt <= {tcfg_initval, 2'b0};
                else
                    timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // Setting wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset)
            timer_irq <= 1'b0;
        else if (timer_cnt == '0)
            timer_irq <= 1'b1;
        else if (ticlr_wr)
            timer_irq <= 1'b0;
    end

    always_comb begin
        case (idx)
            IDX_TID:  rd_word = tid;
            IDX_TCFG: rd_word = tcfg_word;
            IDX_TVAL: rd_word = timer_cnt;
            default:  rd_word = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/csr_save_bank.sv ====
`default_nettype none

module csr_save_bank
    import csr_map_pkg::*;
(
    input  logic                  clk,
    input  logic                  wr_en,
    input  csr_idx_t              idx,
    input  logic [CSR_DATA_W-1:0] wr_data,
    input  logic [CSR_DATA_W-1:0] wr_mask,
    output logic [CSR_DATA_W-1:0] rd_word
);

    logic [CSR_DATA_W-1:0] save_q [4];
    logic [1:0]            sel;
    logic                  hit;

    always_comb begin
        hit = 1'b1;
        case (idx)
            IDX_SAVE0: sel = 2'd0;
            IDX_SAVE1: sel = 2'd1;
            IDX_SAVE2: sel = 2'd2;
            IDX_SAVE3: sel = 2'd3;
            default: begin
                sel = 2'd0;
                hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_en && hit)
            save_q[sel] <= csr_merge(save_q[sel], wr_data, wr_mask & SAVE_WMASK);
    end

    assign rd_word = hit ? save_q[sel] : '0;

endmodule

`default_nettype wire

// ==== src/csr_top.sv ====
`default_nettype none

module csr_top
    import csr_map_pkg::*;
    import csr_exc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [CSR_NUM_W-1:0]  wb_adr,
    input  logic [CSR_DATA_W-1:0] wb_dat_w,
    input  logic [CSR_DATA_W-1:0] wb_mask,
    output logic                  wb_ack,
    output logic [CSR_DATA_W-1:0] wb_dat_r,

    input  logic                  ex_valid,
    input  logic [ECODE_W-1:0]    ex_ecode,
    input  logic [ESUBCODE_W-1:0] ex_esubcode,
    input  logic [CSR_DATA_W-1:0] ex_pc,
    input  logic [CSR_DATA_W-1:0] ex_vaddr,
    input  logic                  ertn,

    output logic [CSR_DATA_W-1:0] ex_entry,
    output logic [CSR_DATA_W-1:0] era_pc,
    output logic                  has_int
);

    logic                  wr_en;
    csr_idx_t              idx;
    logic [CSR_DATA_W-1:0] wr_data;
    logic [CSR_DATA_W-1:0] wr_mask;
    logic [CSR_DATA_W-1:0] rd_exc, rd_timer, rd_save;
    logic                  timer_irq;
    logic                  ticlr_wr;

    csr_bus_ctrl u_bus (
        .clk, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_mask, .wb_ack, .wb_dat_r,
        .rd_exc, .rd_timer, .rd_save,
        .wr_en, .idx, .wr_data, .wr_mask
    );

    csr_exc_regs u_exc (
        .clk, .reset,
        .wr_en, .idx, .wr_data, .wr_mask, .rd_word(rd_exc),
        .ex_valid, .ex_ecode, .ex_esubcode, .ex_pc, .ex_vaddr, .ertn, .timer_irq,
        .ex_entry, .era_pc, .has_int, .ticlr_wr
    );

    csr_timer u_timer (
        .clk, .reset,
        .wr_en, .idx, .wr_data, .wr_mask, .ticlr_wr,
        .rd_word(rd_timer), .timer_irq
    );

    csr_save_bank u_save (
        .clk,
        .wr_en, .idx, .wr_data, .wr_mask,
        .rd_word(rd_save)
    );

endmodule

`default_nettype wire

// ==== dv/csr_checker.sv ====
`default_nettype none

module csr_checker (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic has_int,
    input logic ex_valid
);

    // Ack only ever answers a request seen on the previous edge
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack rose without a request in the previous cycle");

    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held high for two cycles");

    // Exception entry clears CRMD.IE and so masks every interrupt
    int_off_after_ex: assert property (@(posedge clk) disable iff (reset)
        ex_valid |=> !has_int)
        else $error("has_int high after exception entry cleared CRMD.IE");

endmodule

bind csr_top csr_checker chk0 (
    .clk(clk),
    .reset(reset),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_ack(wb_ack),
    .has_int(has_int),
    .ex_valid(ex_valid)
);

`default_nettype wire

// ==== dv/csr_tb.sv ====
`default_nettype none

module csr_tb
    import csr_map_pkg::*;
    import csr_exc_pkg::*;
();

    localparam int          ACK_TIMEOUT = 16;
    localparam int          INT_TIMEOUT = 200;
    localparam logic [15:0] LFSR_SEED   = 16'd84;
    localparam logic [ECODE_W-1:0] ECODE_OTHER = 6'h0b;
    localparam logic [CSR_NUM_W-1:0] CSR_UNMAPPED = 14'h0123;
    localparam logic [CSR_NUM_W-1:0] RAND_REGS [9] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG,
        CSR_EENTRY, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID};

    logic                  clk, reset;
    logic                  wb_cyc, wb_stb, wb_we, wb_ack;
    logic [CSR_NUM_W-1:0]  wb_adr;
    logic [CSR_DATA_W-1:0] wb_dat_w, wb_mask, wb_dat_r;
    logic                  ex_valid, ertn, has_int;
    logic [ECODE_W-1:0]    ex_ecode;
    logic [ESUBCODE_W-1:0] ex_esubcode;
    logic [CSR_DATA_W-1:0] ex_pc, ex_vaddr, ex_entry, era_pc;

    // Reference copy of the register state
    logic [31:0] m_crmd, m_prmd, m_ecfg, m_estat, m_era, m_badv, m_eentry, m_tid, m_tcfg;
    logic [31:0] m_save [4];
    logic        m_tirq;

    logic [15:0] lfsr;
    int          n_mismatch, n_other;
    logic        exp_on;
    logic [31:0] exp_val, exp_mask;
    string       exp_name;

    csr_top dut0 (
        .clk, .reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_mask, .wb_ack, .wb_dat_r,
        .ex_valid, .ex_ecode, .ex_esubcode, .ex_pc, .ex_vaddr, .ertn,
        .ex_entry, .era_pc, .has_int
    );

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] merged(input logic [31:0] old_v, new_v, m);
        return (old_v & ~m) | (new_v & m);
    endfunction

    function automatic void model_write(input logic [13:0] adr, input logic [31:0] d, m);
        case (adr)
            CSR_CRMD:   m_crmd    = merged(m_crmd, d, m & CRMD_WMASK);
            CSR_PRMD:   m_prmd    = merged(m_prmd, d, m & PRMD_WMASK);
            CSR_ECFG:   m_ecfg    = merged(m_ecfg, d, m & ECFG_WMASK);
            CSR_ESTAT:  m_estat   = merged(m_estat, d, m & ESTAT_WMASK);
            CSR_ERA:    m_era     = merged(m_era, d, m);
            CSR_EENTRY: m_eentry  = merged(m_eentry, d, m & EENTRY_WMASK);
            CSR_SAVE0:  m_save[0] = merged(m_save[0], d, m & SAVE_WMASK);
            CSR_SAVE1:  m_save[1] = merged(m_save[1], d, m & SAVE_WMASK);
            CSR_SAVE2:  m_save[2] = merged(m_save[2], d, m & SAVE_WMASK);
            CSR_SAVE3:  m_save[3] = merged(m_save[3], d, m & SAVE_WMASK);
            CSR_TID:    m_tid     = merged(m_tid, d, m);
            CSR_TCFG:   m_tcfg    = merged(m_tcfg, d, m & TCFG_WMASK);
            // Only issued once the counter is idle
            CSR_TICLR:  if (m[0] && d[0]) m_tirq = 1'b0;
            default:    ;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input logic [13:0] adr);
        case (adr)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ECFG:   return m_ecfg;
            CSR_ESTAT:  return m_estat | ({31'b0, m_tirq} << TIMER_IRQ_BIT);
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0:  return m_save[0];
            CSR_SAVE1:  return m_save[1];
            CSR_SAVE2:  return m_save[2];
            CSR_SAVE3:  return m_save[3];
            CSR_TID:    return m_tid;
            CSR_TCFG:   return m_tcfg;
            // Only the idle count is predictable
            CSR_TVAL:   return TIMER_IDLE;
            default:    return '0;
        endcase
    endfunction

    function automatic void model_exception(input logic [5:0] ecode, input logic [8:0] esub,
                                            input logic [31:0] pc, vaddr);
        m_prmd  = {29'b0, m_crmd[2:0]};
        m_crmd  = m_crmd & ~32'h7;
        // Esubcode 30:22, ecode 21:16, software IS kept
        m_estat = {1'b0, esub, ecode, 14'b0, m_estat[1:0]};
        m_era   = pc;
        if (ecode == ECODE_ADE && esub == ESUBCODE_ADEF)
            m_badv = pc;
        else if (ecode == ECODE_ADE || ecode == ECODE_ALE)
            m_badv = vaddr;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            n_mismatch++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    // Read data is stable in the middle of the ack cycle
    always @(negedge clk) begin
        if (wb_ack && exp_on)
            check(exp_name, wb_dat_r & exp_mask, exp_val & exp_mask);
    end

    task automatic bus_xfer(input logic we, input logic [13:0] adr, input logic [31:0] d, m,
                            input logic [31:0] cmask, output logic [31:0] rdata);
        int n;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = d;
        wb_mask  = m;
        exp_on   = !we;
        exp_val  = model_read(adr);
        exp_mask = cmask;
        exp_name = $sformatf("wb_dat_r of CSR %h", adr);
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack && n < ACK_TIMEOUT);
        if (!wb_ack) begin
            n_other++;
            $display("timeout waiting for wb_ack on CSR %h", adr);
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic csr_write(input logic [13:0] adr, input logic [31:0] d, m);
        logic [31:0] discard;
        bus_xfer(1'b1, adr, d, m, '0, discard);
        model_write(adr, d, m);
    endtask

    task automatic csr_read(input logic [13:0] adr, input logic [31:0] cmask,
                            output logic [31:0] v);
        bus_xfer(1'b0, adr, '0, '0, cmask, v);
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] esub,
                                   input logic [31:0] pc, vaddr);
        @(posedge clk);
        #1;
        ex_valid    = 1'b1;
        ex_ecode    = ecode;
        ex_esubcode = esub;
        ex_pc       = pc;
        ex_vaddr    = vaddr;
        @(posedge clk);
        #1;
        ex_valid = 1'b0;
        model_exception(ecode, esub, pc, vaddr);
    endtask

    task automatic pulse_ertn();
        @(posedge clk);
        #1;
        ertn = 1'b1;
        @(posedge clk);
        #1;
        ertn = 1'b0;
        m_crmd = (m_crmd & ~32'h7) | (m_prmd & 32'h7);
    endtask

    task automatic wait_has_int(input logic level, input string what);
        int n;
        n = 0;
        while (has_int !== level && n < INT_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (has_int !== level) begin
            n_other++;
            $display("timeout: has_int never went to %0d during %s", level, what);
        end
    endtask

    initial begin
        logic [31:0] d, m, v, prev, pc, va;
        clk = 1'b0;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_mask = '0;
        ex_valid = 1'b0;
        ex_ecode = '0;
        ex_esubcode = '0;
        ex_pc = '0;
        ex_vaddr = '0;
        ertn = 1'b0;
        lfsr = LFSR_SEED;
        n_mismatch = 0;
        n_other = 0;
        exp_on = 1'b0;
        exp_val = '0;
        exp_mask = '0;
        exp_name = "";
        m_crmd = {28'b0, CRMD_DA_CONST, 3'b0};
        // Bits outside the writable fields always read zero
        m_prmd = '0;
        m_eentry = '0;
        m_ecfg = '0;
        m_estat = '0;
        m_tirq = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // Reset values, ESTAT fields above IS are not reset
        csr_read(CSR_CRMD, '1, v);
        csr_read(CSR_ECFG, '1, v);
        csr_read(CSR_ESTAT, {{(32 - IS_W){1'b0}}, {IS_W{1'b1}}}, v);
        csr_read(CSR_TVAL, '1, v);
        check("has_int", {31'b0, has_int}, 32'd0);

        // Full writes first so no field is left unknown
        for (int i = 0; i < 9; i++) begin
            rand_bits(32, d);
            csr_write(RAND_REGS[i], d, '1);
        end
        for (int i = 0; i < 45; i++) begin
            rand_bits(32, d);
            rand_bits(32, m);
            csr_write(RAND_REGS[i % 9], d, m);
            csr_read(RAND_REGS[i % 9], '1, v);
        end
        rand_bits(32, d);
        csr_write(CSR_UNMAPPED, d, '1);
        csr_read(CSR_UNMAPPED, '1, v);

        // Exception entry and return
        csr_write(CSR_CRMD, 32'h7, 32'h7);
        rand_bits(32, pc);
        rand_bits(32, va);
        raise_exception(ECODE_OTHER, 9'h0, pc, va);
        check("era_pc", era_pc, m_era);
        check("ex_entry", ex_entry, m_eentry);
        csr_read(CSR_CRMD, '1, v);
        csr_read(CSR_PRMD, '1, v);
        csr_read(CSR_ESTAT, '1, v);
        pulse_ertn();
        csr_read(CSR_CRMD, '1, v);

        // BADV source depends on the code
        rand_bits(32, pc);
        rand_bits(32, va);
        raise_exception(ECODE_ADE, ESUBCODE_ADEF, pc, va);
        csr_read(CSR_BADV, '1, v);
        rand_bits(32, pc);
        rand_bits(32, va);
        raise_exception(ECODE_ALE, 9'h0, pc, va);
        csr_read(CSR_BADV, '1, v);
        rand_bits(32, pc);
        rand_bits(32, va);
        raise_exception(ECODE_OTHER, 9'h0, pc, va);
        csr_read(CSR_BADV, '1, v);
        csr_read(CSR_ESTAT, '1, v);

        // One-shot timer, initval 8
        csr_write(CSR_ECFG, 32'h1 << TIMER_IRQ_BIT, '1);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        csr_write(CSR_TCFG, {30'd8, 1'b0, 1'b1}, '1);
        csr_read(CSR_TCFG, '1, v);
        csr_read(CSR_TVAL, '0, prev);
        for (int i = 0; i < 3; i++) begin
            csr_read(CSR_TVAL, '0, v);
            check("TVAL decreasing", {31'b0, v < prev}, 32'd1);
            prev = v;
        end
        wait_has_int(1'b1, "timer countdown");
        m_tirq = 1'b1;
        csr_read(CSR_ESTAT, '1, v);
        csr_read(CSR_TVAL, '1, v);
        csr_write(CSR_TICLR, 32'h1, 32'h1);
        check("has_int", {31'b0, has_int}, 32'd0);
        csr_read(CSR_ESTAT, '1, v);

        // Software interrupt on IS[1]
        csr_write(CSR_ECFG, 32'h3, '1);
        csr_write(CSR_CRMD, 32'h4, 32'h4);
        csr_write(CSR_ESTAT, 32'h2, 32'h3);
        wait_has_int(1'b1, "software interrupt");
        csr_read(CSR_ESTAT, '1, v);

        // Exception masks the pending interrupt until ertn
        rand_bits(32, pc);
        rand_bits(32, va);
        raise_exception(ECODE_OTHER, 9'h0, pc, va);
        check("has_int", {31'b0, has_int}, 32'd0);
        pulse_ertn();
        wait_has_int(1'b1, "return from exception");
        csr_write(CSR_CRMD, 32'h0, 32'h4);
        check("has_int", {31'b0, has_int}, 32'd0);

        finish_run();
    end

endmodule

`default_nettype wire

// ==== compile.f ====
src/csr_map_pkg.sv
src/csr_exc_pkg.sv
src/csr_bus_ctrl.sv
src/csr_exc_regs.sv
src/csr_timer.sv
src/csr_save_bank.sv
src/csr_top.sv
dv/csr_checker.sv
dv/csr_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = csr_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
